/* rd_guard.f */
rtl/rd_guard_pkg.sv
rtl/rd_guard_decode.sv
rtl/rd_guard_slots.sv
rtl/rd_guard_report.sv
rtl/rd_guard_top.sv
tb/rd_guard_checker.sv
tb/rd_guard_tb.sv

/* tb/rd_guard_tb.sv */
module rd_guard_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rd_guard_pkg::*;

  localparam int MaxReads    = 16;
  localparam int NoBeat      = 100000;
  localparam int BudgetFirst = 20;
  localparam int BudgetBeat  = 4;
  localparam int LenReset    = 4;
  localparam int LenRandom   = 200;
  localparam int LenFirst    = 30;
  localparam int LenClear    = 4;
  localparam int LenBurst    = 34;
  localparam int LenUnwanted = 30;
  localparam int LenOverflow = 34;
  localparam int CycleLimit  = 2 * (LenReset + LenRandom + LenFirst + LenClear + LenBurst +
                                    LenUnwanted + LenOverflow) + 200;

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  logic        irq_o;
  logic        reset_req_o;
  ar_beat_t    ar_i;
  r_beat_t     r_i;
  guard_cfg_t  cfg_i;
  viol_t       viol_o;
  lat_report_t lat_o;

  int    seed = 77;
  int    cycles = 0;
  int    n_reads;
  id_t   rd_id [MaxReads];
  addr_t rd_addr [MaxReads];
  len_t  rd_len [MaxReads];
  int    rd_ar [MaxReads];
  int    rd_first [MaxReads];
  int    rd_last [MaxReads];
  int    unw_at;
  id_t   unw_id;
  int    ov_at;
  id_t   ov_id;
  addr_t ov_addr;

  rd_guard_top dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ar_i        (ar_i),
    .r_i         (r_i),
    .cfg_i       (cfg_i),
    .clear_i     (clear_i),
    .irq_o       (irq_o),
    .reset_req_o (reset_req_o),
    .viol_o      (viol_o),
    .lat_o       (lat_o)
  );

  rd_guard_checker u_checker (
    .clk_i       (clk_i),
    .cfg_i       (cfg_i),
    .irq_i       (irq_o),
    .reset_req_i (reset_req_o),
    .viol_i      (viol_o),
    .lat_i       (lat_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("timeout: the run went past %0d cycles without finishing", CycleLimit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic int pick(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic void clear_plan();
    n_reads = 0;
    unw_at  = NoBeat;
    ov_at   = NoBeat;
  endfunction

  function automatic void add_plan(input id_t id, input addr_t addr, input len_t len,
                                   input int ar, input int first, input int last);
    rd_id[n_reads]    = id;
    rd_addr[n_reads]  = addr;
    rd_len[n_reads]   = len;
    rd_ar[n_reads]    = ar;
    rd_first[n_reads] = first;
    rd_last[n_reads]  = last;
    n_reads++;
  endfunction

  // Reads whose slot is still held at the given address handshake
  function automatic int count_live(input int c);
    int n;
    n = 0;
    for (int k = 0; k < n_reads; k++) begin
      if (rd_ar[k] < c && rd_last[k] >= c) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic bit beat_taken(input int c);
    for (int k = 0; k < n_reads; k++) begin
      if (rd_first[k] == c || rd_last[k] == c) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic drive_cycle(input int c);
    ar_i = '0;
    r_i  = '0;
    // Stray valid without ready must be ignored by the guard
    if (pick(4) == 0) begin
      ar_i.valid = 1'b1;
      ar_i.id    = id_t'(pick(16));
    end
    if (pick(4) == 0) begin
      r_i.valid = 1'b1;
      r_i.id    = id_t'(pick(16));
    end
    for (int k = 0; k < n_reads; k++) begin
      if (rd_ar[k] == c) begin
        ar_i = '{valid: 1'b1, ready: 1'b1, id: rd_id[k], addr: rd_addr[k], len: rd_len[k]};
      end
      if (rd_first[k] == c || rd_last[k] == c) begin
        r_i = '{valid: 1'b1, ready: 1'b1, id: rd_id[k], last: rd_last[k] == c};
      end
    end
    if (ov_at == c) begin
      ar_i = '{valid: 1'b1, ready: 1'b1, id: ov_id, addr: ov_addr, len: '0};
    end
    if (unw_at == c) begin
      r_i = '{valid: 1'b1, ready: 1'b1, id: unw_id, last: 1'b1};
    end
  endtask

  // Starts on a falling edge and ends with a clear pulse
  task automatic run_schedule(input string name, input int len);
    u_checker.begin_test(name);
    for (int k = 0; k < n_reads; k++) begin
      u_checker.add_read(rd_id[k], rd_addr[k], rd_len[k], rd_ar[k], rd_first[k], rd_last[k]);
    end
    if (unw_at != NoBeat) begin
      u_checker.add_unwanted(unw_at);
    end
    if (ov_at != NoBeat) begin
      u_checker.add_overflow(ov_at, ov_addr);
    end
    for (int c = 0; c < len; c++) begin
      drive_cycle(c);
      @(negedge clk_i);
    end
    ar_i = '0;
    r_i  = '0;
    @(negedge clk_i);
    u_checker.end_test();
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
  endtask

  task automatic test_random();
    int  ar;
    int  first;
    int  last;
    int  prev_last [3];
    id_t id;
    len_t len;
    clear_plan();
    cfg_i     = '{budget_first: cnt_t'(200), budget_beat: cnt_t'(30)};
    prev_last = '{-1, -1, -1};
    ar        = 0;
    for (int k = 0; k < 10; k++) begin
      id  = id_t'(pick(3));
      len = len_t'(pick(4));
      ar  = ar + 1 + pick(4);
      while (count_live(ar) >= NumSlots) begin
        ar++;
      end
      // Same-ID responses wait for the older read to finish
      first = ar + 1 + pick(4);
      if (first <= prev_last[id]) begin
        first = prev_last[id] + 1;
      end
      while (beat_taken(first)) begin
        first++;
      end
      last = (len == 0) ? first : first + 1 + pick(2 * (int'(len) + 1));
      while (beat_taken(last)) begin
        last++;
      end
      prev_last[id] = last;
      add_plan(id, 32'h1000_0000 + k * 32'h40, len, ar, first, last);
    end
    run_schedule("random_in_order", LenRandom);
    cfg_i = '{budget_first: cnt_t'(BudgetFirst), budget_beat: cnt_t'(BudgetBeat)};
  endtask

  initial begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    ar_i    = '0;
    r_i     = '0;
    cfg_i   = '{budget_first: cnt_t'(BudgetFirst), budget_beat: cnt_t'(BudgetBeat)};
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    clear_plan();
    run_schedule("reset_state", LenReset);

    test_random();

    // First data far past the budget so the late beat finds no read
    clear_plan();
    add_plan(4'h1, 32'h2000_0100, 8'd0, 1, BudgetFirst + 6, BudgetFirst + 6);
    run_schedule("first_timeout", LenFirst);
    clear_plan();
    run_schedule("clear_after_timeout", LenClear);

    // Same burst delay of 9 against limits of 8 and 16
    clear_plan();
    add_plan(4'h2, 32'h3000_0200, 8'd1, 1, 3, 12);
    add_plan(4'h3, 32'h3000_0300, 8'd3, 16, 18, 27);
    run_schedule("burst_timeout", LenBurst);

    clear_plan();
    unw_at = 2;
    unw_id = 4'h5;
    add_plan(4'h6, 32'h4000_0400, 8'd0, 4, NoBeat, NoBeat);
    run_schedule("unwanted_then_timeout", LenUnwanted);

    clear_plan();
    for (int k = 0; k < NumSlots; k++) begin
      add_plan(id_t'(k), 32'h5000_0000 + k * 32'h100, 8'd0, 1 + k, NoBeat, NoBeat);
    end
    ov_at   = NumSlots + 1;
    ov_id   = 4'h8;
    ov_addr = 32'h5000_0f00;
    run_schedule("table_overflow", LenOverflow);

    u_checker.summary();
    if (u_checker.error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tb/rd_guard_checker.sv */
module rd_guard_checker (
  input logic                      clk_i,
  input rd_guard_pkg::guard_cfg_t  cfg_i,
  input logic                      irq_i,
  input logic                      reset_req_i,
  input rd_guard_pkg::viol_t       viol_i,
  input rd_guard_pkg::lat_report_t lat_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import rd_guard_pkg::*;

  localparam int MaxReads = 16;

  // Event cycle is counted in drive cycles from the start of a test
  typedef struct packed {
    cause_e kind;
    int     at;
    cnt_t   first_lat;
    cnt_t   burst_lat;
  } outcome_t;

  string test_name;
  int    error_count = 0;
  int    test_count = 0;
  int    test_errors;
  bit    active = 1'b0;
  int    cyc = 0;
  int    seen_viol;
  int    n_reads;
  id_t   rd_id [MaxReads];
  addr_t rd_addr [MaxReads];
  len_t  rd_len [MaxReads];
  int    rd_ar [MaxReads];
  int    rd_first [MaxReads];
  int    rd_last [MaxReads];
  bit    matched [MaxReads];
  int    unw_at;
  int    ov_at;
  addr_t ov_addr;

  // Expected fate of one read under the current budgets
  function automatic outcome_t predict(input int k);
    outcome_t o;
    int       lim;
    lim         = (int'(rd_len[k]) + 1) * int'(cfg_i.budget_beat);
    o.kind      = CauseNone;
    o.at        = rd_last[k];
    o.first_lat = cnt_t'(rd_first[k] - rd_ar[k]);
    o.burst_lat = cnt_t'(rd_last[k] - rd_first[k]);
    if (rd_first[k] - rd_ar[k] > int'(cfg_i.budget_first)) begin
      o.kind = CauseFirstTimeout;
      o.at   = rd_ar[k] + int'(cfg_i.budget_first) + 1;
    end else if (rd_last[k] - rd_first[k] > lim) begin
      o.kind = CauseBurstTimeout;
      o.at   = rd_first[k] + lim + 1;
    end
    return o;
  endfunction

  task automatic flag_mismatch(input string what, input longint exp, input longint act);
    $display("error %s: %s expected %0d actual %0d", test_name, what, exp, act);
    test_errors++;
    error_count++;
  endtask

  task automatic flag_problem(input string msg);
    $display("test %s: %s", test_name, msg);
    test_errors++;
    error_count++;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    n_reads     = 0;
    unw_at      = -1;
    ov_at       = -1;
    test_errors = 0;
    seen_viol   = -1;
    cyc         = 0;
    active      = 1'b1;
  endtask

  task automatic add_read(input id_t id, input addr_t addr, input len_t len,
                          input int ar, input int first, input int last);
    rd_id[n_reads]    = id;
    rd_addr[n_reads]  = addr;
    rd_len[n_reads]   = len;
    rd_ar[n_reads]    = ar;
    rd_first[n_reads] = first;
    rd_last[n_reads]  = last;
    matched[n_reads]  = 1'b0;
    n_reads++;
  endtask

  task automatic add_unwanted(input int c);
    unw_at = c;
  endtask

  task automatic add_overflow(input int c, input addr_t addr);
    ov_at   = c;
    ov_addr = addr;
  endtask

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // Registered outputs are stable on the falling edge
  always @(negedge clk_i) begin
    outcome_t o;
    bit       found;
    if (active && cyc > 0) begin
      if (lat_i.valid) begin
        found = 1'b0;
        for (int k = 0; k < n_reads; k++) begin
          o = predict(k);
          if (!found && !matched[k] && o.kind == CauseNone && o.at + 1 == cyc) begin
            found      = 1'b1;
            matched[k] = 1'b1;
            if (lat_i.id != rd_id[k]) begin
              flag_mismatch("report id", rd_id[k], lat_i.id);
            end
            if (lat_i.first_lat != o.first_lat) begin
              flag_mismatch("first latency", o.first_lat, lat_i.first_lat);
            end
            if (lat_i.burst_lat != o.burst_lat) begin
              flag_mismatch("burst latency", o.burst_lat, lat_i.burst_lat);
            end
          end
        end
        if (!found) begin
          flag_problem($sformatf("latency report at cycle %0d belongs to no finished read", cyc));
        end
      end
      if (viol_i.valid && seen_viol < 0) begin
        seen_viol = cyc;
      end
    end
  end

  task automatic end_test();
    outcome_t o;
    cause_e   exp_cause;
    addr_t    exp_addr;
    int       exp_at;
    exp_cause = CauseNone;
    exp_addr  = '0;
    exp_at    = -1;
    // Ties go to unwanted, then overflow, then timeouts
    if (unw_at >= 0) begin
      exp_cause = CauseUnwanted;
      exp_at    = unw_at;
    end
    if (ov_at >= 0 && (exp_at < 0 || ov_at < exp_at)) begin
      exp_cause = CauseOverflow;
      exp_addr  = ov_addr;
      exp_at    = ov_at;
    end
    for (int k = 0; k < n_reads; k++) begin
      o = predict(k);
      if (o.kind == CauseNone) begin
        if (!matched[k]) begin
          flag_problem($sformatf("no latency report for the read at address %0h", rd_addr[k]));
        end
      end else if (exp_at < 0 || o.at < exp_at) begin
        exp_cause = o.kind;
        exp_addr  = rd_addr[k];
        exp_at    = o.at;
      end
    end
    if (viol_i.valid != (exp_at >= 0)) begin
      flag_mismatch("violation valid", exp_at >= 0, viol_i.valid);
    end
    if (viol_i.cause != exp_cause) begin
      flag_mismatch("cause", exp_cause, viol_i.cause);
    end
    if (viol_i.addr != exp_addr) begin
      flag_mismatch("violation address", exp_addr, viol_i.addr);
    end
    if (exp_at >= 0 && seen_viol != exp_at + 1) begin
      flag_mismatch("violation cycle", exp_at + 1, seen_viol);
    end
    if (irq_i != (exp_at >= 0)) begin
      flag_mismatch("irq", exp_at >= 0, irq_i);
    end
    if (reset_req_i != (exp_at >= 0)) begin
      flag_mismatch("reset request", exp_at >= 0, reset_req_i);
    end
    active = 1'b0;
    test_count++;
    if (test_errors == 0) begin
      $display("test %s: pass", test_name);
    end else begin
      $display("test %s: fail with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic summary();
    $display("tests run %0d, errors %0d", test_count, error_count);
  endtask

endmodule

/* rtl/rd_guard_top.sv */
module rd_guard_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rd_guard_pkg::ar_beat_t    ar_i,
  input  rd_guard_pkg::r_beat_t     r_i,
  input  rd_guard_pkg::guard_cfg_t  cfg_i,
  input  logic                      clear_i,
  output logic                      irq_o,
  output logic                      reset_req_o,
  output rd_guard_pkg::viol_t       viol_o,
  output rd_guard_pkg::lat_report_t lat_o
);
  import rd_guard_pkg::*;

  slot_cmd_t                 cmd;
  viol_t                     dec_viol;
  viol_t                     slot_viol;
  lat_report_t               slot_lat;
  slot_view_t [NumSlots-1:0] view;
  logic [NumSlots-1:0]       complete;

  // Bus beats into slot commands
  rd_guard_decode u_decode (
    .ar_i       (ar_i),
    .r_i        (r_i),
    .view_i     (view),
    .complete_i (complete),
    .cmd_o      (cmd),
    .viol_o     (dec_viol)
  );

  rd_guard_slots u_slots (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_i      (cmd),
    .cfg_i      (cfg_i),
    .view_o     (view),
    .complete_o (complete),
    .viol_o     (slot_viol),
    .lat_o      (slot_lat)
  );

  // Sticky flags and registered outputs
  rd_guard_report u_report (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dec_viol_i  (dec_viol),
    .slot_viol_i (slot_viol),
    .lat_i       (slot_lat),
    .clear_i     (clear_i),
    .irq_o       (irq_o),
    .reset_req_o (reset_req_o),
    .viol_o      (viol_o),
    .lat_o       (lat_o)
  );

endmodule

/* rtl/rd_guard_report.sv */
module rd_guard_report (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rd_guard_pkg::viol_t       dec_viol_i,
  input  rd_guard_pkg::viol_t       slot_viol_i,
  input  rd_guard_pkg::lat_report_t lat_i,
  input  logic                      clear_i,
  output logic                      irq_o,
  output logic                      reset_req_o,
  output rd_guard_pkg::viol_t       viol_o,
  output rd_guard_pkg::lat_report_t lat_o
);
  import rd_guard_pkg::*;

  viol_t       win;
  logic        take;
  viol_t       viol_q;
  logic        irq_q;
  logic        reset_req_q;
  logic        lat_valid_q;
  lat_report_t lat_q;

  // Decode-time violations come before timeouts
  assign win  = dec_viol_i.valid ? dec_viol_i : slot_viol_i;
  // Keep only the first one, a fresh violation beats a clear
  assign take = win.valid && (!viol_q.valid || clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_q <= '{valid: 1'b0, cause: CauseNone, addr: '0};
    end else if (take) begin
      viol_q <= win;
    end else if (clear_i) begin
      viol_q <= '{valid: 1'b0, cause: CauseNone, addr: '0};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q       <= 1'b0;
      reset_req_q <= 1'b0;
    end else if (win.valid) begin
      irq_q       <= 1'b1;
      reset_req_q <= 1'b1;
    end else if (clear_i) begin
      irq_q       <= 1'b0;
      reset_req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_valid_q <= 1'b0;
    end else begin
      lat_valid_q <= lat_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lat_i.valid) begin
      lat_q <= lat_i;
    end
  end

  always_comb begin
    lat_o       = lat_q;
    lat_o.valid = lat_valid_q;
  end

  assign irq_o       = irq_q;
  assign reset_req_o = reset_req_q;
  assign viol_o      = viol_q;

  irq_pair_a: assert property (@(posedge clk_i) disable iff (!rst_ni) irq_o == reset_req_o)
    else $error("report: interrupt and reset request disagree");

endmodule

/* rtl/rd_guard_slots.sv */
module rd_guard_slots (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  rd_guard_pkg::slot_cmd_t                                cmd_i,
  input  rd_guard_pkg::guard_cfg_t                               cfg_i,
  output rd_guard_pkg::slot_view_t [rd_guard_pkg::NumSlots-1:0] view_o,
  output logic [rd_guard_pkg::NumSlots-1:0]                      complete_o,
  output rd_guard_pkg::viol_t                                    viol_o,
  output rd_guard_pkg::lat_report_t                              lat_o
);
  import rd_guard_pkg::*;

  typedef struct packed {
    id_t       id;
    addr_t     addr;
    len_t      len;
    slot_idx_t order;
    cnt_t      first_lat;
    cnt_t      cnt_first;
    cnt_t      cnt_burst;
  } slot_t;

  phase_e                 phase_q [NumSlots];
  slot_t                  slot_q [NumSlots];
  logic [NumSlots-1:0]    live;
  logic [NumSlots-1:0]    alloc_hit;
  logic [NumSlots-1:0]    beat_hit;
  logic [NumSlots-1:0]    first_to;
  logic [NumSlots-1:0]    burst_to;
  logic [NumSlots-1:0]    done;
  logic [BudgetWidth-1:0] burst_lim [NumSlots];
  slot_idx_t              order_drop [NumSlots];
  logic                   order_clash;

  // Counters stick at their maximum instead of wrapping
  function automatic cnt_t cnt_inc(cnt_t cnt);
    return (cnt == '1) ? cnt : cnt + 1'b1;
  endfunction

  always_comb begin
    for (int i = 0; i < NumSlots; i++) begin
      live[i]       = phase_q[i] != PhFree;
      alloc_hit[i]  = cmd_i.alloc.valid && cmd_i.alloc.idx == slot_idx_t'(i);
      beat_hit[i]   = cmd_i.data.valid && cmd_i.data.idx == slot_idx_t'(i);
      burst_lim[i]  = (BudgetWidth'(slot_q[i].len) + 1'b1) * BudgetWidth'(cfg_i.budget_beat);
      first_to[i]   = phase_q[i] == PhAddr && slot_q[i].cnt_first > cfg_i.budget_first;
      burst_to[i]   = phase_q[i] == PhData && BudgetWidth'(slot_q[i].cnt_burst) > burst_lim[i];
      // A late slot is dropped even if its last beat shows up now
      done[i]       = live[i] && beat_hit[i] && cmd_i.data.last && !first_to[i] && !burst_to[i];
      complete_o[i] = first_to[i] || burst_to[i] || done[i];
      view_o[i]     = '{live: live[i], id: slot_q[i].id, order: slot_q[i].order};
    end
  end

  // Each leaving read of the same ID that was ahead moves this one up by one
  always_comb begin
    for (int i = 0; i < NumSlots; i++) begin
      order_drop[i] = '0;
      for (int j = 0; j < NumSlots; j++) begin
        if (complete_o[j] && slot_q[j].id == slot_q[i].id &&
            slot_q[j].order < slot_q[i].order) begin
          order_drop[i] = order_drop[i] + 1'b1;
        end
      end
    end
  end

  // Lowest timed-out slot and the single completion of this cycle
  always_comb begin
    viol_o = '{valid: 1'b0, cause: CauseNone, addr: '0};
    lat_o  = '{valid: 1'b0, id: '0, first_lat: '0, burst_lat: '0};
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (first_to[i] || burst_to[i]) begin
        viol_o.valid = 1'b1;
        viol_o.cause = first_to[i] ? CauseFirstTimeout : CauseBurstTimeout;
        viol_o.addr  = slot_q[i].addr;
      end
      if (done[i]) begin
        lat_o.valid = 1'b1;
        lat_o.id    = slot_q[i].id;
        // Single-beat read finishes straight from the address phase
        if (phase_q[i] == PhAddr) begin
          lat_o.first_lat = slot_q[i].cnt_first;
          lat_o.burst_lat = '0;
        end else begin
          lat_o.first_lat = slot_q[i].first_lat;
          lat_o.burst_lat = slot_q[i].cnt_burst;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumSlots; i++) begin
        phase_q[i] <= PhFree;
      end
    end else begin
      for (int i = 0; i < NumSlots; i++) begin
        if (alloc_hit[i]) begin
          phase_q[i] <= PhAddr;
        end else if (complete_o[i]) begin
          phase_q[i] <= PhFree;
        end else if (beat_hit[i] && phase_q[i] == PhAddr) begin
          phase_q[i] <= PhData;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumSlots; i++) begin
      if (alloc_hit[i]) begin
        slot_q[i].id        <= cmd_i.alloc.id;
        slot_q[i].addr      <= cmd_i.alloc.addr;
        slot_q[i].len       <= cmd_i.alloc.len;
        slot_q[i].order     <= cmd_i.alloc.order;
        slot_q[i].cnt_first <= cnt_t'(1);
        slot_q[i].cnt_burst <= '0;
      end else if (live[i]) begin
        slot_q[i].order <= slot_q[i].order - order_drop[i];
        if (phase_q[i] == PhAddr) begin
          if (beat_hit[i]) begin
            slot_q[i].first_lat <= slot_q[i].cnt_first;
            slot_q[i].cnt_burst <= cnt_t'(1);
          end else begin
            slot_q[i].cnt_first <= cnt_inc(slot_q[i].cnt_first);
          end
        end else begin
          slot_q[i].cnt_burst <= cnt_inc(slot_q[i].cnt_burst);
        end
      end
    end
  end

  always_comb begin
    order_clash = 1'b0;
    for (int i = 0; i < NumSlots; i++) begin
      for (int j = i + 1; j < NumSlots; j++) begin
        if (live[i] && live[j] && slot_q[i].id == slot_q[j].id &&
            slot_q[i].order == slot_q[j].order) begin
          order_clash = 1'b1;
        end
      end
    end
  end

  order_unique_a: assert property (@(posedge clk_i) disable iff (!rst_ni) !order_clash)
    else $error("slots: two live reads share an ID and an order number");

  data_live_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_i.data.valid |-> phase_q[cmd_i.data.idx] != PhFree)
    else $error("slots: data beat sent to a free slot");

endmodule

/* rtl/rd_guard_decode.sv */
module rd_guard_decode (
  input  rd_guard_pkg::ar_beat_t                                 ar_i,
  input  rd_guard_pkg::r_beat_t                                  r_i,
  input  rd_guard_pkg::slot_view_t [rd_guard_pkg::NumSlots-1:0] view_i,
  input  logic [rd_guard_pkg::NumSlots-1:0]                      complete_i,
  output rd_guard_pkg::slot_cmd_t                                cmd_o,
  output rd_guard_pkg::viol_t                                    viol_o
);
  import rd_guard_pkg::*;

  logic                ar_fire;
  logic                r_fire;
  logic                full;
  slot_idx_t           free_idx;
  slot_idx_t           alloc_order;
  logic [NumSlots-1:0] hit;
  slot_idx_t           hit_idx;

  assign ar_fire = ar_i.valid && ar_i.ready;
  assign r_fire  = r_i.valid && r_i.ready;

  // Lowest free slot wins
  always_comb begin
    full     = 1'b1;
    free_idx = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (!view_i[i].live) begin
        full     = 1'b0;
        free_idx = slot_idx_t'(i);
      end
    end
  end

  // Older reads of the same ID, a slot leaving this cycle no longer counts
  always_comb begin
    alloc_order = '0;
    for (int i = 0; i < NumSlots; i++) begin
      if (view_i[i].live && !complete_i[i] && view_i[i].id == ar_i.id) begin
        alloc_order = alloc_order + 1'b1;
      end
    end
  end

  // A data beat belongs to the oldest read of its ID
  always_comb begin
    hit_idx = '0;
    for (int i = 0; i < NumSlots; i++) begin
      hit[i] = view_i[i].live && view_i[i].id == r_i.id && view_i[i].order == '0;
      if (hit[i]) begin
        hit_idx = slot_idx_t'(i);
      end
    end
  end

  assign cmd_o.alloc = '{valid: ar_fire && !full, idx: free_idx, id: ar_i.id,
                         addr: ar_i.addr, len: ar_i.len, order: alloc_order};
  assign cmd_o.data  = '{valid: r_fire && (|hit), idx: hit_idx, last: r_i.last};

  // Unwanted response outranks overflow
  always_comb begin
    viol_o = '{valid: 1'b0, cause: CauseNone, addr: '0};
    if (r_fire && !(|hit)) begin
      viol_o = '{valid: 1'b1, cause: CauseUnwanted, addr: '0};
    end else if (ar_fire && full) begin
      viol_o = '{valid: 1'b1, cause: CauseOverflow, addr: ar_i.addr};
    end
  end

  alloc_free_a: assert final (!cmd_o.alloc.valid || !view_i[cmd_o.alloc.idx].live)
    else $error("decode: allocation names a live slot");

  hit_unique_a: assert final ($onehot0(hit))
    else $error("decode: data beat matches more than one slot");

endmodule

/* rtl/rd_guard_pkg.sv */
package rd_guard_pkg;

  localparam int unsigned IdWidth      = 4;
  localparam int unsigned AddrWidth    = 32;
  // A burst carries len+1 beats
  localparam int unsigned LenWidth     = 8;
  localparam int unsigned CntWidth     = 12;
  localparam int unsigned NumSlots     = 8;
  localparam int unsigned SlotIdxWidth = 3;
  // Wide enough for (len+1) * budget_beat
  localparam int unsigned BudgetWidth  = LenWidth + CntWidth + 1;

  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [LenWidth-1:0]     len_t;
  typedef logic [CntWidth-1:0]     cnt_t;
  typedef logic [SlotIdxWidth-1:0] slot_idx_t;

  typedef enum logic [1:0] {
    PhFree,
    PhAddr,
    PhData
  } phase_e;

  typedef enum logic [2:0] {
    CauseNone,
    CauseUnwanted,
    CauseOverflow,
    CauseFirstTimeout,
    CauseBurstTimeout
  } cause_e;

  typedef struct packed {
    logic  valid;
    logic  ready;
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_beat_t;

  typedef struct packed {
    logic valid;
    logic ready;
    id_t  id;
    logic last;
  } r_beat_t;

  typedef struct packed {
    cnt_t budget_first;
    cnt_t budget_beat;
  } guard_cfg_t;

  typedef struct packed {
    logic      live;
    id_t       id;
    slot_idx_t order;
  } slot_view_t;

  typedef struct packed {
    logic      valid;
    slot_idx_t idx;
    id_t       id;
    addr_t     addr;
    len_t      len;
    // Number of older reads with the same ID
    slot_idx_t order;
  } alloc_cmd_t;

  typedef struct packed {
    logic      valid;
    slot_idx_t idx;
    logic      last;
  } data_cmd_t;

  typedef struct packed {
    alloc_cmd_t alloc;
    data_cmd_t  data;
  } slot_cmd_t;

  typedef struct packed {
    logic   valid;
    cause_e cause;
    addr_t  addr;
  } viol_t;

  typedef struct packed {
    logic valid;
    id_t  id;
    cnt_t first_lat;
    cnt_t burst_lat;
  } lat_report_t;

endpackage
